// File: bench/minimum_trigger_testdata.txt
# I <beat>                  input beat, 16 hex digits, lane 3 first, lane 0 last
# E <word> <tlast> <tuser>  expected output word in order; T <name> names the lines after it
T baseline_learning
I 07D007CC07D407D0
I 07CE07D207C607DA
I 07D507CF07D307D1
I 07D307D207D007CB
T quiet_no_trigger
I 07D007CF07D107D0
I 07D107D007D207CE
I 07CF07D007CD07D3
T threshold_edge
I 07D107CF070807D0
I 07D107CE07D007D2
T first_event
I 0762058C05DC07CB
I 07D007D107BC076C
I 07D207CF051407D0
I 07CE07D307D007CF
E 0001000007D0058C 0 1
E 07D107CF070807D0 0 0
E 07D107CE07D007D2 0 0
E 0762058C05DC07CB 0 0
E 07D007D107BC076C 0 0
E 07D207CF051407D0 0 0
E 07CE07D307D007CF 1 0
T retrigger_after_holdoff
I 067207D107CF06A4
I 07C607D0079E0708
I 07D007CF07D207D1
I 07D007D007D007D0
E 0002000107D00672 0 1
E 07D207CF051407D0 0 0
E 07CE07D307D007CF 0 0
E 067207D107CF06A4 0 0
E 07C607D0079E0708 0 0
E 07D007CF07D207D1 0 0
E 07D007D007D007D0 1 0
T backpressure_tail
I 07CF07D107D307CE
I 07D207D007CC07D4
I 07D007D107CF07D0

// File: all.f
+incdir+rtl
rtl/trig_pkg.sv
rtl/beat_if.sv
rtl/baseline_calc.sv
rtl/time_stamper.sv
rtl/min_trigger_detect.sv
rtl/event_packer.sv
rtl/minimum_trigger.sv
bench/tb_clock.sv
bench/minimum_trigger_props.sv
bench/minimum_trigger_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module minimum_trigger_tb -f all.f -o minimum_trigger_sim \
    && ./obj_dir/minimum_trigger_sim > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: bench/minimum_trigger_tb.sv
`include "trig_consts.svh"

module minimum_trigger_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import trig_pkg::*;

    localparam string DATA_FILE   = "bench/minimum_trigger_testdata.txt";
    localparam int    DRIVE_DELAY = 2;

    logic               AXIS_ACLK;
    logic               AXIS_ARESETN;
    logic [`BEAT_W-1:0] s_axis_tdata;
    logic               s_axis_tvalid;
    logic               s_axis_tready;
    logic [`BEAT_W-1:0] m_axis_tdata;
    logic               m_axis_tvalid;
    logic               m_axis_tready;
    logic               m_axis_tlast;
    logic               m_axis_tuser;
    logic               fifo_full;

    logic [`BEAT_W-1:0] in_beats [$];
    out_word_t          exp_words [$];
    logic               exp_last [$];
    logic               exp_user [$];
    string              exp_names [$];

    integer seed             = 32'h9203;
    int     n_expected       = 0;
    int     n_checked        = 0;
    int     cycle_count      = 0;
    int     cycle_limit      = 0;
    logic   saw_backpressure = 1'b0;

    tb_clock u_clock (
        .clk (AXIS_ACLK)
    );

    minimum_trigger i_dut (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .fifo_full     (fifo_full)
    );

    bind minimum_trigger minimum_trigger_props u_props (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .fifo_full     (fifo_full)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("[ERROR] %s: expected 0x%0h, actual 0x%0h",
                                        name, expected, actual));
        end
    endtask

    // Lines are T <name>, I <beat> or E <word> <last> <user>
    task automatic load_testdata();
        int          fd;
        int          rc;
        string       line;
        string       tag;
        string       test_name;
        logic [63:0] word;
        int          last;
        int          user;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
        begin
            stop_with_failure({"Cannot open the data file ", DATA_FILE});
        end
        test_name = "unnamed";
        while (!$feof(fd))
        begin
            line = "";
            rc   = $fgets(line, fd);
            if (rc > 0 && $sscanf(line, "%s", tag) == 1)
            begin
                if (tag == "T")
                begin
                    rc = $sscanf(line, "%s %s", tag, test_name);
                end
                else if (tag == "I")
                begin
                    if ($sscanf(line, "%s %h", tag, word) != 2)
                    begin
                        stop_with_failure({"Malformed input line: ", line});
                    end
                    in_beats.push_back(word);
                end
                else if (tag == "E")
                begin
                    if ($sscanf(line, "%s %h %d %d", tag, word, last, user) != 4)
                    begin
                        stop_with_failure({"Malformed expected line: ", line});
                    end
                    exp_words.push_back(out_word_t'(word));
                    exp_last.push_back(last != 0);
                    exp_user.push_back(user != 0);
                    exp_names.push_back(test_name);
                end
                else if (tag != "#")
                begin
                    stop_with_failure({"Unknown line in the data file: ", line});
                end
            end
        end
        $fclose(fd);
    endtask

    // Headers are compared field by field, data beats as a whole
    task automatic check_word(input int idx);
        out_word_t act;
        out_word_t exp;
        string     name;
        act  = out_word_t'(m_axis_tdata);
        exp  = exp_words[idx];
        name = $sformatf("%s word %0d", exp_names[idx], idx);
        if (exp_user[idx])
        begin
            check_value({name, " stamp"}, 64'(exp.hdr.stamp), 64'(act.hdr.stamp));
            check_value({name, " count"}, 64'(exp.hdr.count), 64'(act.hdr.count));
            check_value({name, " baseline"}, 64'(exp.hdr.baseline), 64'(act.hdr.baseline));
            check_value({name, " minimum"}, 64'(exp.hdr.min_sample), 64'(act.hdr.min_sample));
        end
        else
        begin
            check_value({name, " data"}, exp.data, act.data);
        end
        check_value({name, " tuser"}, 64'(exp_user[idx]), 64'(m_axis_tuser));
        check_value({name, " tlast"}, 64'(exp_last[idx]), 64'(m_axis_tlast));
    endtask

    task automatic drive_beats();
        int   idx;
        logic taken;
        idx = 0;
        while (idx < in_beats.size())
        begin
            s_axis_tdata  = in_beats[idx];
            s_axis_tvalid = 1'b1;
            // Ready is settled by the falling edge
            @(negedge AXIS_ACLK);
            taken = s_axis_tready;
            @(posedge AXIS_ACLK);
            #DRIVE_DELAY;
            if (taken)
            begin
                idx++;
            end
        end
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
    endtask

    // Sink stalls about one cycle in three
    always @(posedge AXIS_ACLK)
    begin
        #DRIVE_DELAY;
        m_axis_tready = AXIS_ARESETN && (($unsigned($random(seed)) % 3) != 0);
    end

    always @(negedge AXIS_ACLK)
    begin
        if (s_axis_tvalid && !s_axis_tready)
        begin
            saw_backpressure = 1'b1;
        end
        // Full needs a whole FIFO of words that are still to come out
        if (n_expected - n_checked < `FIFO_DEPTH)
        begin
            check_value("fifo_full_level", 64'(0), 64'(fifo_full));
        end
        if (m_axis_tvalid && m_axis_tready)
        begin
            if (n_checked >= n_expected)
            begin
                stop_with_failure($sformatf("Unexpected extra output word 0x%0h",
                                            m_axis_tdata));
            end
            else
            begin
                check_word(n_checked);
                n_checked++;
            end
        end
    end

    always @(posedge AXIS_ACLK)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            stop_with_failure($sformatf("Timeout after %0d cycles, %0d of %0d words seen",
                                        cycle_count, n_checked, n_expected));
        end
    end

    initial
    begin
        AXIS_ARESETN  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        load_testdata();
        n_expected  = exp_words.size();
        cycle_limit = 4 * (in_beats.size() + n_expected) + 100;
        repeat (2) @(posedge AXIS_ACLK);
        #DRIVE_DELAY;
        AXIS_ARESETN = 1'b1;
        // Skip the dead ready cycle after reset
        repeat (2) @(posedge AXIS_ACLK);
        #DRIVE_DELAY;
        drive_beats();
        wait (n_checked == n_expected);
        // Quiet tail so a stray word still shows up
        repeat (10) @(posedge AXIS_ACLK);
        if (!saw_backpressure)
        begin
            stop_with_failure("Input was never back-pressured by the output FIFO");
        end
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: bench/minimum_trigger_props.sv
`include "trig_consts.svh"

module minimum_trigger_props (
    input logic               AXIS_ACLK,
    input logic               AXIS_ARESETN,
    input logic               s_axis_tready,
    input logic [`BEAT_W-1:0] m_axis_tdata,
    input logic               m_axis_tvalid,
    input logic               m_axis_tready,
    input logic               m_axis_tlast,
    input logic               m_axis_tuser,
    input logic               fifo_full
);
    timeunit 1ns;
    timeprecision 1ps;

    // Output word held while the sink stalls
    stall_stable: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
            && $stable(m_axis_tlast) && $stable(m_axis_tuser))
        else $error("Output word changed during a stall");

    reset_idle: assert property (@(posedge AXIS_ACLK)
        !AXIS_ARESETN |=> !m_axis_tvalid && !s_axis_tready && !fifo_full)
        else $error("Outputs not idle after reset");

    // One dead cycle on the input after reset
    ready_late: assert property (@(posedge AXIS_ACLK)
        $rose(AXIS_ARESETN) |-> !s_axis_tready)
        else $error("Input ready in the first cycle out of reset");

    // A queued event starts with its header
    header_after_last: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        m_axis_tvalid && m_axis_tready && m_axis_tlast |=> !m_axis_tvalid || m_axis_tuser)
        else $error("Word after the last word of an event is not a header");

    header_not_last: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        m_axis_tvalid |-> !(m_axis_tlast && m_axis_tuser))
        else $error("Header word marked as last");

endmodule

// File: bench/tb_clock.sv
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS = 40;

    // Free running, first rising edge after half a period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: rtl/minimum_trigger.sv
`include "trig_consts.svh"

module minimum_trigger (
    input  logic              AXIS_ACLK,
    input  logic              AXIS_ARESETN,
    input  logic [`BEAT_W-1:0] s_axis_tdata,
    input  logic              s_axis_tvalid,
    output logic              s_axis_tready,
    output logic [`BEAT_W-1:0] m_axis_tdata,
    output logic              m_axis_tvalid,
    input  logic              m_axis_tready,
    output logic              m_axis_tlast,
    output logic              m_axis_tuser,
    output logic              fifo_full
);

    logic                         run;
    logic                         accept;
    logic [$clog2(`FIFO_DEPTH):0] fifo_free;

    beat_if bl_to_ts ();
    beat_if ts_to_det ();
    beat_if det_to_pk ();

    // Holds ready low for the first cycle out of reset
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            run <= 1'b0;
        end
        else
        begin
            run <= 1'b1;
        end
    end

    // Room for a full event plus the beats already in the pipeline
    assign s_axis_tready = run && (fifo_free >= `EVENT_WORDS + 4);
    assign accept        = s_axis_tvalid && s_axis_tready;

    baseline_calc u_baseline_calc (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .in_beat      (s_axis_tdata),
        .in_strobe    (accept),
        .out          (bl_to_ts)
    );

    time_stamper u_time_stamper (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .in           (bl_to_ts),
        .out          (ts_to_det)
    );

    min_trigger_detect u_min_trigger_detect (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .in           (ts_to_det),
        .out          (det_to_pk)
    );

    event_packer u_event_packer (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .in            (det_to_pk),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .fifo_free     (fifo_free),
        .fifo_full     (fifo_full)
    );

endmodule

// File: rtl/event_packer.sv
`include "trig_consts.svh"

module event_packer (
    input  logic                          AXIS_ACLK,
    input  logic                          AXIS_ARESETN,
    beat_if.dst                           in,
    output logic [`BEAT_W-1:0]            m_axis_tdata,
    output logic                          m_axis_tvalid,
    input  logic                          m_axis_tready,
    output logic                          m_axis_tlast,
    output logic                          m_axis_tuser,
    output logic [$clog2(`FIFO_DEPTH):0]  fifo_free,
    output logic                          fifo_full
);
    import trig_pkg::*;

    // Words entered at a trigger: header, pre beats, trigger beat
    localparam int GRP    = `PRE_BEATS + 2;
    localparam int GRP_W  = $clog2(GRP + 1);
    localparam int POST_W = $clog2(`POST_BEATS + 1);
    localparam int PTR_W  = $clog2(`FIFO_DEPTH);
    localparam int CNT_W  = PTR_W + 1;

    sample_beat_t     dly [`PRE_BEATS];
    out_word_t        hdr_word;
    logic [15:0]      event_cnt;
    logic [POST_W-1:0] post_left;

    // Staging queue between the stage and the FIFO write port
    out_word_t        stg_word [GRP];
    logic [GRP_W-1:0] stg_n;
    logic             stg_user;
    logic             stg_last;

    out_word_t        mem_data [`FIFO_DEPTH];
    logic             mem_last [`FIFO_DEPTH];
    logic             mem_user [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             rd_en;

    always_comb
    begin
        hdr_word.hdr.stamp      = in.stamp;
        hdr_word.hdr.count      = event_cnt;
        hdr_word.hdr.baseline   = 16'(in.baseline);
        hdr_word.hdr.min_sample = 16'(in.beat_min);
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            event_cnt <= '0;
            post_left <= '0;
            stg_n     <= '0;
            stg_user  <= 1'b0;
            stg_last  <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
        end
        else
        begin
            stg_n    <= '0;
            stg_user <= 1'b0;
            stg_last <= 1'b0;
            if (in.strobe && in.trigger)
            begin
                stg_n     <= GRP_W'(GRP);
                stg_user  <= 1'b1;
                stg_last  <= (`POST_BEATS == 0);
                post_left <= POST_W'(`POST_BEATS);
                event_cnt <= event_cnt + 1'b1;
            end
            else if (in.strobe && post_left != '0)
            begin
                stg_n     <= GRP_W'(1);
                stg_last  <= (post_left == POST_W'(1));
                post_left <= post_left - 1'b1;
            end
            wr_ptr <= wr_ptr + PTR_W'(stg_n);
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(stg_n) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        // Pre-trigger history of armed beats, dly[0] newest
        if (in.strobe && in.armed)
        begin
            dly[0] <= in.beat;
            for (int i = 1; i < `PRE_BEATS; i++)
            begin
                dly[i] <= dly[i-1];
            end
        end
        // A plain data beat sits in slot 0 unless a header is due
        if (in.trigger)
        begin
            stg_word[0] <= hdr_word;
        end
        else
        begin
            stg_word[0].data <= in.beat;
        end
        for (int i = 0; i < `PRE_BEATS; i++)
        begin
            stg_word[i+1].data <= dly[`PRE_BEATS-1-i];
        end
        stg_word[GRP-1].data <= in.beat;

        // Whole staging group goes into the FIFO in one cycle
        for (int i = 0; i < GRP; i++)
        begin
            if (i < stg_n)
            begin
                mem_data[PTR_W'(wr_ptr + i)] <= stg_word[i];
                mem_last[PTR_W'(wr_ptr + i)] <= stg_last && (i == stg_n - 1);
                mem_user[PTR_W'(wr_ptr + i)] <= stg_user && (i == 0);
            end
        end
    end

    assign rd_en         = m_axis_tvalid && m_axis_tready;
    assign m_axis_tvalid = (count != '0);
    assign m_axis_tdata  = mem_data[rd_ptr];
    assign m_axis_tlast  = m_axis_tvalid && mem_last[rd_ptr];
    assign m_axis_tuser  = m_axis_tvalid && mem_user[rd_ptr];

    assign fifo_free = CNT_W'(`FIFO_DEPTH) - count;
    assign fifo_full = (count == CNT_W'(`FIFO_DEPTH));

endmodule

// File: rtl/min_trigger_detect.sv
`include "trig_consts.svh"

module min_trigger_detect (
    input  logic AXIS_ACLK,
    input  logic AXIS_ARESETN,
    beat_if.dst  in,
    beat_if.src  out
);

    localparam int HOLD_W = $clog2(`POST_BEATS + 1);
    // Room for baseline plus threshold without wrap
    localparam int CMP_W  = `ADC_W + 2;

    logic [`ADC_W-1:0] lane_min;
    logic [HOLD_W-1:0] holdoff;
    logic              below;
    logic              fire;

    // Lowest sample of the beat
    always_comb
    begin
        lane_min = in.beat[0][`ADC_W-1:0];
        for (int i = 1; i < `LANES; i++)
        begin
            if (in.beat[i][`ADC_W-1:0] < lane_min)
            begin
                lane_min = in.beat[i][`ADC_W-1:0];
            end
        end
    end

    // min < baseline - THRESHOLD, rearranged to stay unsigned
    assign below = (CMP_W'(lane_min) + CMP_W'(`THRESHOLD)) < CMP_W'(in.baseline);
    assign fire  = in.strobe && in.armed && below && (holdoff == '0);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            holdoff     <= '0;
            out.strobe  <= 1'b0;
            out.armed   <= 1'b0;
            out.trigger <= 1'b0;
        end
        else
        begin
            out.strobe  <= in.strobe;
            out.armed   <= in.armed;
            out.trigger <= fire;
            // No retrigger while post beats are still being taken
            if (fire)
            begin
                holdoff <= HOLD_W'(`POST_BEATS);
            end
            else if (in.strobe && holdoff != '0)
            begin
                holdoff <= holdoff - 1'b1;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        out.beat     <= in.beat;
        out.baseline <= in.baseline;
        out.stamp    <= in.stamp;
        out.beat_min <= lane_min;
    end

endmodule

// File: rtl/time_stamper.sv
`include "trig_consts.svh"

module time_stamper (
    input  logic AXIS_ACLK,
    input  logic AXIS_ARESETN,
    beat_if.dst  in,
    beat_if.src  out
);

    localparam int DIV_W = $clog2(`TICK_DIV);

    logic [DIV_W-1:0]    div_cnt;
    logic [`STAMP_W-1:0] tick_cnt;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            div_cnt     <= '0;
            tick_cnt    <= '0;
            out.strobe  <= 1'b0;
            out.armed   <= 1'b0;
            out.trigger <= 1'b0;
        end
        else
        begin
            out.strobe  <= in.strobe;
            out.armed   <= in.armed;
            out.trigger <= in.trigger;
            // Only armed beats advance time
            if (in.strobe && in.armed)
            begin
                if (div_cnt == DIV_W'(`TICK_DIV - 1))
                begin
                    div_cnt  <= '0;
                    tick_cnt <= tick_cnt + 1'b1;
                end
                else
                begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    // Stamp is the tick count before this beat's own increment
    always_ff @(posedge AXIS_ACLK)
    begin
        out.beat     <= in.beat;
        out.baseline <= in.baseline;
        out.beat_min <= in.beat_min;
        out.stamp    <= tick_cnt;
    end

endmodule

// File: rtl/baseline_calc.sv
`include "trig_consts.svh"

module baseline_calc (
    input  logic                  AXIS_ACLK,
    input  logic                  AXIS_ARESETN,
    input  trig_pkg::sample_beat_t in_beat,
    input  logic                  in_strobe,
    beat_if.src                   out
);

    localparam int SHIFT = $clog2(`LANES * `BASELINE_BEATS);
    localparam int SUM_W = `ADC_W + SHIFT;
    localparam int CNT_W = $clog2(`BASELINE_BEATS + 1);

    logic [SUM_W-1:0] acc;
    logic [SUM_W-1:0] beat_sum;
    logic [CNT_W-1:0] learn_cnt;
    logic             learned;

    assign learned = (learn_cnt == CNT_W'(`BASELINE_BEATS));

    // Sum of the four samples of the current beat
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < `LANES; i++)
        begin
            beat_sum = beat_sum + SUM_W'(in_beat[i][`ADC_W-1:0]);
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            acc        <= '0;
            learn_cnt  <= '0;
            out.strobe <= 1'b0;
            out.armed  <= 1'b0;
        end
        else
        begin
            out.strobe <= in_strobe;
            // Goes high with the first beat after learning
            out.armed  <= learned;
            if (in_strobe && !learned)
            begin
                acc       <= acc + beat_sum;
                learn_cnt <= learn_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        out.beat <= in_beat;
    end

    // Mean is the sum over 16 samples, so a plain shift
    assign out.baseline = acc[SUM_W-1 -: `ADC_W];

    // Produced further down the pipeline
    assign out.stamp    = '0;
    assign out.trigger  = 1'b0;
    assign out.beat_min = '0;

endmodule

// File: rtl/beat_if.sv
`include "trig_consts.svh"

interface beat_if;
    import trig_pkg::*;

    sample_beat_t        beat;
    logic                strobe;
    logic                armed;
    logic [`ADC_W-1:0]   baseline;
    logic [`STAMP_W-1:0] stamp;
    // Pulse, valid together with strobe
    logic                trigger;
    logic [`ADC_W-1:0]   beat_min;

    modport src (
        output beat, strobe, armed, baseline, stamp, trigger, beat_min
    );

    modport dst (
        input beat, strobe, armed, baseline, stamp, trigger, beat_min
    );

endinterface

// File: rtl/trig_pkg.sv
`include "trig_consts.svh"

package trig_pkg;

    // One input beat, lane 0 in the low bits
    typedef logic [`LANES-1:0][`LANE_W-1:0] sample_beat_t;

    // Header layout of an event
    typedef struct packed {
        logic [`STAMP_W-1:0] stamp;
        logic [15:0]         count;
        logic [15:0]         baseline;
        logic [15:0]         min_sample;
    } hdr_word_t;

    // Output FIFO word, either a header or a data beat
    typedef union packed {
        hdr_word_t    hdr;
        sample_beat_t data;
    } out_word_t;

endpackage

// File: rtl/trig_consts.svh
`ifndef TRIG_CONSTS_SVH
`define TRIG_CONSTS_SVH

// Beat format, four ADC samples in 16-bit lanes
`define LANES          4
`define ADC_W          12
`define LANE_W         16
`define BEAT_W         64

// Baseline learning, mean of LANES * BASELINE_BEATS samples
`define BASELINE_BEATS 4

// Trigger depth below the baseline in ADC counts
`define THRESHOLD      200

// Capture window around the trigger beat
`define PRE_BEATS      2
`define POST_BEATS     3
`define EVENT_WORDS    (1 + `PRE_BEATS + 1 + `POST_BEATS)

// Time stamp in ticks of TICK_DIV armed beats
`define TICK_DIV       4
`define STAMP_W        16

`define FIFO_DEPTH     16

`endif
